/* sim.f */
src/canny_pkg.sv
src/fifo.sv
src/sobel_gradient.sv
src/non_maximum_suppressor.sv
src/canny_edge_stage.sv
test/canny_edge_stage_assertions.sv
test/canny_edge_stage_tb.sv

/* test/canny_patterns.txt */
// Column 1: input pixel, column 2: expected suppressed output, both hex
// 8 by 6 image in raster order, a 70 block on a 10 background
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a f0
0a f0
0a 00
0a 00
0a 00
0a 00
0a 00
46 ff
46 f0
46 f0
46 ff
0a 00
0a 00
0a 00
0a f0
46 f0
46 00
46 00
46 f0
0a f0
0a 00
0a 00
0a 00
46 ff
46 f0
46 f0
46 ff
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00
0a 00

/* test/canny_edge_stage_tb.sv */
`timescale 1ns/1ps

module canny_edge_stage_tb
    import canny_pkg::*;
;

    localparam int WIDTH         = 8;
    localparam int HEIGHT        = 6;
    localparam int FIFO_DEPTH    = 16;
    localparam int PIXELS        = WIDTH*HEIGHT;
    // Frames sent over all tests together
    localparam int TOTAL_FRAMES  = 6;
    localparam int MAX_CYCLES    = 20*TOTAL_FRAMES*PIXELS + 200;
    localparam int PAUSE_CYCLES  = 30;
    localparam int SETTLE_CYCLES = 20;

    logic   clock;
    logic   rst;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;

    // Even entries hold input pixels, odd entries the expected outputs
    pixel_t patterns [2*PIXELS];

    integer seed;
    int     error_count;
    int     test_count;
    int     failed_tests;
    int     cycle_count;

    canny_edge_stage #(
        .WIDTH      (WIDTH),
        .HEIGHT     (HEIGHT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clock     (clock),
        .rst       (rst),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the output stream stalled", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic pixel_t pixel_in(input int index);
        return patterns[2*index];
    endfunction

    function automatic pixel_t pixel_expected(input int index);
        return patterns[2*index + 1];
    endfunction

    // True with the given percentage
    function automatic bit draw_read(input int percent);
        return ($unsigned($random(seed)) % 100) < percent;
    endfunction

    task automatic check_pixel(input pixel_t actual, input pixel_t expected,
                               input string name, input int index);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s[%0d] = %02h, expected %02h",
                     $time, name, index, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // Stream frames through the pipeline and compare every output pixel
    task automatic run_frames(input string name, input int frames, input int read_percent,
                              input bit stall);
        int total;
        int written;
        int received;
        int pause_left;
        int errors_before;
        bit full_seen;
        bit reader_go;

        total         = frames*PIXELS;
        written       = 0;
        received      = 0;
        pause_left    = PAUSE_CYCLES;
        errors_before = error_count;
        full_seen     = 1'b0;
        reader_go     = !stall;
        fork
            begin
                while (written < total) begin
                    @(posedge clock);
                    #1;
                    if (in_full)
                        full_seen = 1'b1;
                    if (stall && full_seen && pause_left > 0) begin
                        in_wr_en = 1'b0;
                        pause_left--;
                    end else if (!in_full) begin
                        in_wr_en = 1'b1;
                        in_din   = pixel_in(written % PIXELS);
                        written++;
                    end else begin
                        in_wr_en = 1'b0;
                    end
                end
                @(posedge clock);
                #1;
                in_wr_en = 1'b0;
            end
            begin
                while (received < total) begin
                    @(posedge clock);
                    #1;
                    // Reader stays off until the pipeline backs up
                    if (in_full)
                        reader_go = 1'b1;
                    if (reader_go && !out_empty && draw_read(read_percent)) begin
                        out_rd_en = 1'b1;
                        check_pixel(out_dout, pixel_expected(received % PIXELS),
                                    "out_dout", received);
                        received++;
                    end else begin
                        out_rd_en = 1'b0;
                    end
                end
                @(posedge clock);
                #1;
                out_rd_en = 1'b0;
            end
        join

        if (stall && !full_seen) begin
            error_count++;
            $display("in_full never rose while the reader was held off");
        end

        // Nothing extra may appear once the frames are drained
        repeat (SETTLE_CYCLES) @(posedge clock);
        #1;
        check_bit(out_empty, 1'b1, "out_empty");
        check_bit(in_full, 1'b0, "in_full");
        report_test(name, errors_before);
    endtask

    initial begin
        int errors_before;

        clock        = 1'b0;
        rst          = 1'b1;
        in_wr_en     = 1'b0;
        in_din       = '0;
        out_rd_en    = 1'b0;
        seed         = 31276;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        $readmemh("test/canny_patterns.txt", patterns);

        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;

        errors_before = error_count;
        @(posedge clock);
        #1;
        check_bit(out_empty, 1'b1, "out_empty");
        check_bit(in_full, 1'b0, "in_full");
        report_test("reset_state", errors_before);

        run_frames("frame_result", 1, 100, 1'b0);
        run_frames("back_pressure", 1, 40, 1'b0);
        run_frames("input_stall", 2, 50, 1'b1);
        run_frames("second_frame", 2, 100, 1'b0);

        error_count += DUT.u_assertions.failures;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 test_count, failed_tests, error_count, DUT.u_assertions.failures);
        if (error_count == 0 && failed_tests == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* test/canny_edge_stage_assertions.sv */
`timescale 1ns/1ps

module canny_edge_stage_assertions (
    input logic clock,
    input logic rst,
    input logic pix_rd_en,
    input logic pix_empty,
    input logic grad_wr_en,
    input logic grad_full,
    input logic grad_rd_en,
    input logic grad_empty,
    input logic edge_wr_en,
    input logic edge_full,
    input logic out_empty
);

    // Number of failed properties so far
    int failures = 0;

    // FIFO strobes must respect the flags
    sobel_read_ok: assert property (@(posedge clock) disable iff (rst)
        !(pix_rd_en && pix_empty))
        else begin
            $error("Sobel read from an empty input FIFO");
            failures++;
        end

    sobel_write_ok: assert property (@(posedge clock) disable iff (rst)
        !(grad_wr_en && grad_full))
        else begin
            $error("Sobel wrote into a full middle FIFO");
            failures++;
        end

    nms_read_ok: assert property (@(posedge clock) disable iff (rst)
        !(grad_rd_en && grad_empty))
        else begin
            $error("Suppressor read from an empty middle FIFO");
            failures++;
        end

    nms_write_ok: assert property (@(posedge clock) disable iff (rst)
        !(edge_wr_en && edge_full))
        else begin
            $error("Suppressor wrote into a full output FIFO");
            failures++;
        end

    // Pipeline is idle right after reset
    reset_state: assert property (@(posedge clock)
        rst |=> out_empty && !grad_wr_en && !edge_wr_en)
        else begin
            $error("Pipeline not idle after reset");
            failures++;
        end

endmodule

bind canny_edge_stage canny_edge_stage_assertions u_assertions (
    .clock      (clock),
    .rst        (rst),
    .pix_rd_en  (pix_rd_en),
    .pix_empty  (pix_empty),
    .grad_wr_en (grad_wr_en),
    .grad_full  (grad_full),
    .grad_rd_en (grad_rd_en),
    .grad_empty (grad_empty),
    .edge_wr_en (edge_wr_en),
    .edge_full  (edge_full),
    .out_empty  (out_empty)
);

/* src/canny_edge_stage.sv */
`timescale 1ns/1ps

module canny_edge_stage
    import canny_pkg::*;
#(
    parameter int WIDTH      = 720,
    parameter int HEIGHT     = 540,
    parameter int FIFO_DEPTH = 16
) (
    input  logic   clock,
    input  logic   rst,
    input  logic   in_wr_en,
    input  pixel_t in_din,
    output logic   in_full,
    input  logic   out_rd_en,
    output pixel_t out_dout,
    output logic   out_empty
);

    // Input FIFO to Sobel
    logic   pix_rd_en;
    logic   pix_empty;
    pixel_t pix_dout;

    // Sobel to middle FIFO
    logic   grad_wr_en;
    logic   grad_full;
    grad_t  grad_din;

    // Middle FIFO to suppressor
    logic   grad_rd_en;
    logic   grad_empty;
    grad_t  grad_dout;

    // Suppressor to output FIFO
    logic   edge_wr_en;
    logic   edge_full;
    pixel_t edge_din;

    fifo #(
        .DATA_T     (pixel_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_in_fifo (
        .clock (clock),
        .rst   (rst),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (pix_rd_en),
        .dout  (pix_dout),
        .empty (pix_empty)
    );

    sobel_gradient #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_sobel (
        .clock     (clock),
        .rst       (rst),
        .in_rd_en  (pix_rd_en),
        .in_empty  (pix_empty),
        .in_dout   (pix_dout),
        .out_wr_en (grad_wr_en),
        .out_full  (grad_full),
        .out_din   (grad_din)
    );

    fifo #(
        .DATA_T     (grad_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_mid_fifo (
        .clock (clock),
        .rst   (rst),
        .wr_en (grad_wr_en),
        .din   (grad_din),
        .full  (grad_full),
        .rd_en (grad_rd_en),
        .dout  (grad_dout),
        .empty (grad_empty)
    );

    non_maximum_suppressor #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_nms (
        .clock     (clock),
        .rst       (rst),
        .in_rd_en  (grad_rd_en),
        .in_empty  (grad_empty),
        .in_dout   (grad_dout),
        .out_wr_en (edge_wr_en),
        .out_full  (edge_full),
        .out_din   (edge_din)
    );

    fifo #(
        .DATA_T     (pixel_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .rst   (rst),
        .wr_en (edge_wr_en),
        .din   (edge_din),
        .full  (edge_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

/* src/non_maximum_suppressor.sv */
`timescale 1ns/1ps

module non_maximum_suppressor
    import canny_pkg::*;
#(
    parameter int WIDTH  = 720,
    parameter int HEIGHT = 540
) (
    input  logic   clock,
    input  logic   rst,
    output logic   in_rd_en,
    input  logic   in_empty,
    input  grad_t  in_dout,
    output logic   out_wr_en,
    input  logic   out_full,
    output pixel_t out_din
);

    localparam int SHIFT_REG_LEN = 2*WIDTH + 3;
    localparam int PIXEL_COUNT   = WIDTH*HEIGHT;

    grad_t shift_reg [SHIFT_REG_LEN];
    logic  shift_en;
    grad_t shift_val;

    state_t state, next_state;

    logic [$clog2(WIDTH+2)-1:0]       counter, counter_c;
    logic [$clog2(WIDTH)-1:0]         col, col_c;
    logic [$clog2(HEIGHT)-1:0]        row, row_c;
    logic [$clog2(PIXEL_COUNT+1)-1:0] out_count, out_count_c;

    logic   interior;
    grad_t  centre;
    pixel_t nbr_a, nbr_b;

    // Pick the two neighbors along the centre direction
    always_comb begin
        centre = shift_reg[WIDTH+1];
        case (centre.dir)
            DIR_V: begin
                nbr_a = shift_reg[1].mag;
                nbr_b = shift_reg[2*WIDTH+1].mag;
            end
            DIR_D1: begin
                nbr_a = shift_reg[0].mag;
                nbr_b = shift_reg[2*WIDTH+2].mag;
            end
            DIR_D2: begin
                nbr_a = shift_reg[2].mag;
                nbr_b = shift_reg[2*WIDTH].mag;
            end
            default: begin
                nbr_a = shift_reg[WIDTH].mag;
                nbr_b = shift_reg[WIDTH+2].mag;
            end
        endcase

        interior = (row != 0) && (row != HEIGHT - 1) && (col != 0) && (col != WIDTH - 1);

        // Ties keep the centre, so flat ridges stay connected
        if (interior && centre.mag >= nbr_a && centre.mag >= nbr_b)
            out_din = centre.mag;
        else
            out_din = '0;
    end

    always_comb begin
        next_state  = state;
        counter_c   = counter;
        col_c       = col;
        row_c       = row;
        out_count_c = out_count;
        in_rd_en    = 1'b0;
        out_wr_en   = 1'b0;
        shift_en    = 1'b0;
        shift_val   = in_dout;

        case (state)
            PROLOGUE: begin
                if (!in_empty) begin
                    in_rd_en  = 1'b1;
                    shift_en  = 1'b1;
                    counter_c = counter + 1'b1;
                    if (counter == WIDTH + 1) begin
                        counter_c  = '0;
                        next_state = RUN;
                    end
                end
            end
            RUN: begin
                if (!in_empty && !out_full) begin
                    in_rd_en  = 1'b1;
                    out_wr_en = 1'b1;
                    shift_en  = 1'b1;
                    if (out_count == PIXEL_COUNT - WIDTH - 3)
                        next_state = EPILOGUE;
                end
            end
            EPILOGUE: begin
                // Flush the tail of the frame with zero gradients
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    shift_en  = 1'b1;
                    shift_val = '0;
                    if (out_count == PIXEL_COUNT - 1)
                        next_state = PROLOGUE;
                end
            end
            default: next_state = PROLOGUE;
        endcase

        if (out_wr_en) begin
            out_count_c = (out_count == PIXEL_COUNT - 1) ? '0 : out_count + 1'b1;
            if (col == WIDTH - 1) begin
                col_c = '0;
                row_c = (row == HEIGHT - 1) ? '0 : row + 1'b1;
            end else begin
                col_c = col + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= PROLOGUE;
            counter   <= '0;
            col       <= '0;
            row       <= '0;
            out_count <= '0;
        end else begin
            state     <= next_state;
            counter   <= counter_c;
            col       <= col_c;
            row       <= row_c;
            out_count <= out_count_c;
        end
    end

    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int i = 0; i < SHIFT_REG_LEN - 1; i++)
                shift_reg[i] <= shift_reg[i+1];
            shift_reg[SHIFT_REG_LEN-1] <= shift_val;
        end
    end

endmodule

/* src/sobel_gradient.sv */
`timescale 1ns/1ps

module sobel_gradient
    import canny_pkg::*;
#(
    parameter int WIDTH  = 720,
    parameter int HEIGHT = 540
) (
    input  logic   clock,
    input  logic   rst,
    output logic   in_rd_en,
    input  logic   in_empty,
    input  pixel_t in_dout,
    output logic   out_wr_en,
    input  logic   out_full,
    output grad_t  out_din
);

    localparam int SHIFT_REG_LEN = 2*WIDTH + 3;
    localparam int PIXEL_COUNT   = WIDTH*HEIGHT;

    // Oldest pixel at index 0, newest at the top
    pixel_t shift_reg [SHIFT_REG_LEN];
    logic   shift_en;
    pixel_t shift_val;

    state_t state, next_state;

    logic [$clog2(WIDTH+2)-1:0]       counter, counter_c;
    logic [$clog2(WIDTH)-1:0]         col, col_c;
    logic [$clog2(HEIGHT)-1:0]        row, row_c;
    logic [$clog2(PIXEL_COUNT+1)-1:0] out_count, out_count_c;

    logic   interior;
    sobel_t gx, gy;
    sobel_t abs_gx, abs_gy;
    sobel_t sum;

    function automatic sobel_t widen(input pixel_t p);
        return sobel_t'({4'b0000, p});
    endfunction

    // Window arithmetic around the centre at shift_reg[WIDTH+1]
    always_comb begin
        gx = (widen(shift_reg[2]) + (widen(shift_reg[WIDTH+2]) <<< 1)
              + widen(shift_reg[2*WIDTH+2]))
           - (widen(shift_reg[0]) + (widen(shift_reg[WIDTH]) <<< 1)
              + widen(shift_reg[2*WIDTH]));
        gy = (widen(shift_reg[2*WIDTH]) + (widen(shift_reg[2*WIDTH+1]) <<< 1)
              + widen(shift_reg[2*WIDTH+2]))
           - (widen(shift_reg[0]) + (widen(shift_reg[1]) <<< 1)
              + widen(shift_reg[2]));

        abs_gx = gx[11] ? -gx : gx;
        abs_gy = gy[11] ? -gy : gy;
        sum    = abs_gx + abs_gy;

        interior = (row != 0) && (row != HEIGHT - 1) && (col != 0) && (col != WIDTH - 1);

        if (!interior) begin
            out_din.mag = '0;
            out_din.dir = DIR_H;
        end else begin
            out_din.mag = (sum > 12'sd255) ? 8'hFF : sum[7:0];
            if ((abs_gy <<< 1) < abs_gx)
                out_din.dir = DIR_H;
            else if ((abs_gx <<< 1) < abs_gy)
                out_din.dir = DIR_V;
            else if (gx[11] == gy[11])
                out_din.dir = DIR_D1;
            else
                out_din.dir = DIR_D2;
        end
    end

    always_comb begin
        next_state  = state;
        counter_c   = counter;
        col_c       = col;
        row_c       = row;
        out_count_c = out_count;
        in_rd_en    = 1'b0;
        out_wr_en   = 1'b0;
        shift_en    = 1'b0;
        shift_val   = in_dout;

        case (state)
            PROLOGUE: begin
                // Fill until the first centre pixel is in place
                if (!in_empty) begin
                    in_rd_en  = 1'b1;
                    shift_en  = 1'b1;
                    counter_c = counter + 1'b1;
                    if (counter == WIDTH + 1) begin
                        counter_c  = '0;
                        next_state = RUN;
                    end
                end
            end
            RUN: begin
                if (!in_empty && !out_full) begin
                    in_rd_en  = 1'b1;
                    out_wr_en = 1'b1;
                    shift_en  = 1'b1;
                    // Last input pixel goes in on this step
                    if (out_count == PIXEL_COUNT - WIDTH - 3)
                        next_state = EPILOGUE;
                end
            end
            EPILOGUE: begin
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    shift_en  = 1'b1;
                    shift_val = '0;
                    if (out_count == PIXEL_COUNT - 1)
                        next_state = PROLOGUE;
                end
            end
            default: next_state = PROLOGUE;
        endcase

        // Centre position moves with every written result
        if (out_wr_en) begin
            if (out_count == PIXEL_COUNT - 1)
                out_count_c = '0;
            else
                out_count_c = out_count + 1'b1;
            if (col == WIDTH - 1) begin
                col_c = '0;
                row_c = (row == HEIGHT - 1) ? '0 : row + 1'b1;
            end else begin
                col_c = col + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= PROLOGUE;
            counter   <= '0;
            col       <= '0;
            row       <= '0;
            out_count <= '0;
        end else begin
            state     <= next_state;
            counter   <= counter_c;
            col       <= col_c;
            row       <= row_c;
            out_count <= out_count_c;
        end
    end

    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int i = 0; i < SHIFT_REG_LEN - 1; i++)
                shift_reg[i] <= shift_reg[i+1];
            shift_reg[SHIFT_REG_LEN-1] <= shift_val;
        end
    end

endmodule

/* src/fifo.sv */
`timescale 1ns/1ps

module fifo #(
    parameter type DATA_T     = logic [7:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic  clock,
    input  logic  rst,
    input  logic  wr_en,
    input  DATA_T din,
    output logic  full,
    input  logic  rd_en,
    output DATA_T dout,
    output logic  empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    DATA_T mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // Illegal strobes are simply dropped
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign full  = (count == FIFO_DEPTH);
    assign empty = (count == 0);

    // Show-ahead read port
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (do_write && !do_read)
                count <= count + 1'b1;
            else if (do_read && !do_write)
                count <= count - 1'b1;
        end
    end

endmodule

/* src/canny_pkg.sv */
package canny_pkg;

    // Grayscale pixel, also used for gradient magnitudes
    typedef logic [7:0] pixel_t;

    // Signed Sobel partial sum, wide enough for 4 * 255 plus sign
    typedef logic signed [11:0] sobel_t;

    // Quantized gradient direction
    typedef enum logic [1:0] {
        DIR_H  = 2'd0,  // west / east neighbors
        DIR_V  = 2'd1,  // north / south neighbors
        DIR_D1 = 2'd2,  // north-west / south-east, gx and gy same sign
        DIR_D2 = 2'd3   // north-east / south-west, opposite signs
    } dir_t;

    // Sobel result carried through the middle FIFO
    typedef struct packed {
        pixel_t mag;
        dir_t   dir;
    } grad_t;

    // Window stage control
    typedef enum logic [1:0] {
        PROLOGUE = 2'd0,
        RUN      = 2'd1,
        EPILOGUE = 2'd2
    } state_t;

endpackage
